// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - dcache_way_store.sv
      - dcache_ctrl.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dcache_mem_model.sv
      - dcache_props.sv
      - dcache_tb.sv

// File: dcache_ctrl.sv
// cache FSM, one request in flight, memory requests held as levels until mem_ready
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_ctrl (
	input  logic                        clk,
	input  logic                        proc_reset,
	input  dcache_pkg::proc_req_t       proc_req,
	input  logic                        hit,
	input  logic                        victim_dirty,
	input  logic [`DC_BLOCK_ADDR_W-1:0] victim_block_addr,
	input  logic [`DC_LINE_W-1:0]       victim_line,
	input  logic                        mem_ready,
	output logic                        proc_stall,
	output logic                        word_write,
	output logic                        fill,
	output logic                        clean,
	output dcache_pkg::mem_req_t        mem_req
);

	dcache_pkg::cache_state_e state;
	dcache_pkg::cache_state_e state_nxt;

	logic req_valid;
	logic miss;

	assign req_valid = proc_req.read | proc_req.write;
	assign miss      = req_valid & ~hit;

	// --------------------
	// state register
	// --------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= dcache_pkg::st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// --------------------
	// next state
	// --------------------
	always_comb begin
		state_nxt = state;
		case (state)
			dcache_pkg::st_idle: begin
				state_nxt = dcache_pkg::st_compare_tag;   // single cycle after reset
			end

			dcache_pkg::st_compare_tag: begin
				if (miss) begin
					// dirty victim goes out before the fill
					if (victim_dirty) begin
						state_nxt = dcache_pkg::st_write_back;
					end else begin
						state_nxt = dcache_pkg::st_allocate;
					end
				end
			end

			dcache_pkg::st_write_back: begin
				if (mem_ready) begin
					state_nxt = dcache_pkg::st_allocate;
				end
			end

			dcache_pkg::st_allocate: begin
				if (mem_ready) begin
					state_nxt = dcache_pkg::st_compare_tag;   // request hits there
				end
			end

			default: begin
				state_nxt = dcache_pkg::st_idle;
			end
		endcase
	end

	// --------------------
	// outputs
	// --------------------
	always_comb begin
		proc_stall = 1'b0;
		word_write = 1'b0;
		fill       = 1'b0;
		clean      = 1'b0;
		mem_req    = '0;

		case (state)
			dcache_pkg::st_idle: begin
				proc_stall = req_valid;   // nothing served yet
			end

			dcache_pkg::st_compare_tag: begin
				proc_stall = miss;                 // low in the cycle of a hit
				word_write = proc_req.write & hit;
			end

			dcache_pkg::st_write_back: begin
				proc_stall    = 1'b1;
				mem_req.write = 1'b1;                 // held through the mem_ready cycle
				mem_req.addr  = victim_block_addr;
				mem_req.wdata = victim_line;
				clean         = mem_ready;
			end

			dcache_pkg::st_allocate: begin
				proc_stall   = 1'b1;
				mem_req.read = 1'b1;
				mem_req.addr = proc_req.addr[`DC_ADDR_W-1:`DC_OFFSET_BITS];   // requested block
				fill         = mem_ready;                                     // mem_rdata valid now
			end

			default: begin
				proc_stall = req_valid;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: dcache_macros.svh
// geometry is fixed to 2 ways x 4 sets of 128-bit lines, changing one macro needs the rest kept consistent
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// --------------------
// requester side
// --------------------
`define DC_WORD_W        32   // data word
`define DC_ADDR_W        30   // word address

// --------------------
// line and memory side
// --------------------
`define DC_LINE_W        128  // one cache line, four words
`define DC_BLOCK_ADDR_W  28   // memory block address

// --------------------
// address split
// --------------------
// word address is tag | set | word offset, from high to low
`define DC_OFFSET_BITS   2    // word inside the line
`define DC_SET_BITS      2    // set index
`define DC_NUM_SETS      4    // 2**DC_SET_BITS
`define DC_TAG_W         26   // DC_ADDR_W - DC_SET_BITS - DC_OFFSET_BITS

`endif

// File: dcache_mem_model.sv
// testbench block memory, unwritten blocks read as {block address, word index}, ready after 1 to 6 cycles
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_mem_model (
	input  logic                  clk,
	input  logic                  proc_reset,
	input  dcache_pkg::mem_req_t  mem_req,
	output logic [`DC_LINE_W-1:0] mem_rdata,
	output logic                  mem_ready
);

	logic [`DC_LINE_W-1:0] blocks [logic [`DC_BLOCK_ADDR_W-1:0]];   // written blocks only
	int wait_cnt;

	function automatic logic [`DC_LINE_W-1:0] block_value(input logic [`DC_BLOCK_ADDR_W-1:0] addr);
		logic [`DC_LINE_W-1:0] line;
		if (blocks.exists(addr)) begin
			line = blocks[addr];
		end else begin
			for (int i = 0; i < 4; i++) begin
				line[i*`DC_WORD_W +: `DC_WORD_W] = {addr, 4'(i)};   // initial pattern
			end
		end
		return line;
	endfunction

	initial begin
		mem_ready = 1'b0;
		mem_rdata = '0;
		wait_cnt  = 0;
	end

	// --------------------
	// request service
	// --------------------
	always @(posedge clk) begin
		mem_ready <= 1'b0;   // one-cycle pulse
		if (proc_reset) begin
			wait_cnt <= 0;
		end else if ((mem_req.read || mem_req.write) && !mem_ready) begin
			if (wait_cnt == 0) begin
				wait_cnt <= 1 + ($urandom % 6);   // new request
			end else if (wait_cnt == 1) begin
				wait_cnt  <= 0;
				mem_ready <= 1'b1;
				mem_rdata <= block_value(mem_req.addr);
				if (mem_req.write) begin
					blocks[mem_req.addr] = mem_req.wdata;
				end
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: dcache_pkg.sv
// types shared by cache RTL and testbench, widths come from dcache_macros.svh
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

	// --------------------
	// requester port
	// --------------------
	// read and write are exclusive, held while proc_stall is high
	typedef struct packed {
		logic                  read;
		logic                  write;
		logic [`DC_ADDR_W-1:0] addr;   // word address
		logic [`DC_WORD_W-1:0] wdata;
	} proc_req_t;                      // 64 bits

	// --------------------
	// block memory port
	// --------------------
	// level request, held until memory pulses mem_ready
	typedef struct packed {
		logic                        read;
		logic                        write;
		logic [`DC_BLOCK_ADDR_W-1:0] addr;   // block address
		logic [`DC_LINE_W-1:0]       wdata;  // victim line on write-back
	} mem_req_t;                             // 158 bits

	// one entry of a way
	typedef struct packed {
		logic                 valid;
		logic                 dirty;
		logic [`DC_TAG_W-1:0] tag;
		logic [`DC_LINE_W-1:0] data;
	} line_t;                         // 156 bits

	// cache FSM
	typedef enum logic [1:0] {
		st_idle        = 2'd0,  // one cycle after reset
		st_compare_tag = 2'd1,  // hit check, zero-latency read
		st_write_back  = 2'd2,  // dirty victim out to memory
		st_allocate    = 2'd3   // line fill from memory
	} cache_state_e;

endpackage

`default_nettype wire

// File: dcache_props.sv
// protocol assertions for dcache_top, attached by bind, the FSM state comes in from the controller
`timescale 1ns/100ps
`default_nettype none

module dcache_props (
	input logic                     clk,
	input logic                     proc_reset,
	input dcache_pkg::proc_req_t    proc_req,
	input logic                     proc_stall,
	input dcache_pkg::mem_req_t     mem_req,
	input logic                     mem_ready,
	input dcache_pkg::cache_state_e state
);

	int fail_count = 0;   // summed into the testbench error count

	// --------------------
	// memory side
	// --------------------
	a_mem_one_op: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_req.read && mem_req.write))
	else begin
		fail_count++;
		$error("memory read and write requested in the same cycle");
	end

	// level request held with address and data until mem_ready
	a_mem_stable: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_req.read || mem_req.write) && !mem_ready |=> $stable(mem_req))
	else begin
		fail_count++;
		$error("memory request changed before mem_ready");
	end

	a_mem_quiet_after_reset: assert property (@(posedge clk)
		$fell(proc_reset) |-> !mem_req.read && !mem_req.write)
	else begin
		fail_count++;
		$error("memory request raised in the first cycle after reset");
	end

	// --------------------
	// requester side
	// --------------------
	a_no_stall_when_idle: assert property (@(posedge clk) disable iff (proc_reset)
		state == dcache_pkg::st_compare_tag && !proc_req.read && !proc_req.write
		|-> !proc_stall)
	else begin
		fail_count++;
		$error("proc_stall high in compare_tag without a request");
	end

endmodule

`default_nettype wire

// File: dcache_tb.sv
// testbench for dcache_top with one request at a time and read data checked against a shadow of all writes
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_tb;

	localparam int clk_period      = 8;
	localparam int num_requests    = 313;
	localparam int max_latency     = 8;
	localparam int watchdog_cycles = 100 * num_requests * max_latency;

	logic                        clk;
	logic                        proc_reset;
	dcache_pkg::proc_req_t       proc_req;
	logic [`DC_WORD_W-1:0]       proc_rdata;
	logic                        proc_stall;
	dcache_pkg::mem_req_t        mem_req;
	logic [`DC_LINE_W-1:0]       mem_rdata;
	logic                        mem_ready;

	logic [`DC_WORD_W-1:0] shadow [logic [`DC_ADDR_W-1:0]];   // completed writes
	logic [`DC_BLOCK_ADDR_W-1:0] last_write_addr;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int mem_writes = 0;
	int mem_reads = 0;

	dcache_top i_dcache_top (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	dcache_mem_model i_dcache_mem_model (
		.clk        (clk),
		.proc_reset (proc_reset),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	bind dcache_top dcache_props i_dcache_props (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_req   (proc_req),
		.proc_stall (proc_stall),
		.mem_req    (mem_req),
		.mem_ready  (mem_ready),
		.state      (i_dcache_ctrl.state)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// memory traffic sampled mid-cycle
	always @(negedge clk) begin
		if (mem_ready && mem_req.write) begin
			mem_writes++;
			last_write_addr = mem_req.addr;
		end
		if (mem_ready && mem_req.read) begin
			mem_reads++;
		end
	end

	function automatic logic [`DC_WORD_W-1:0] expected_word(input logic [`DC_ADDR_W-1:0] addr);
		if (shadow.exists(addr)) begin
			return shadow[addr];
		end
		return {addr[`DC_ADDR_W-1:2], 2'b00, addr[1:0]};   // block address, word index
	endfunction

	task automatic check_condition(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("check failed at %0t: %s", $time, what);
		end
	endtask

	// --------------------
	// one request held until the stall drops
	// --------------------
	task automatic access(input logic wr, input logic [`DC_ADDR_W-1:0] addr,
			input logic [`DC_WORD_W-1:0] wdata, output int stall_cycles);
		dcache_pkg::proc_req_t req;
		logic [`DC_WORD_W-1:0] expected;
		req          = '0;
		req.read     = ~wr;
		req.write    = wr;
		req.addr     = addr;
		req.wdata    = wdata;
		stall_cycles = 0;
		@(posedge clk);
		proc_req <= req;
		@(negedge clk);
		while (proc_stall) begin
			stall_cycles++;
			@(negedge clk);
		end
		if (wr) begin
			shadow[addr] = wdata;   // lands at the coming edge
		end else begin
			expected = expected_word(addr);
			checks++;
			assert (proc_rdata === expected) else begin
				errors++;
				$display("mismatch at %0t: read of %h returned %h, expected %h",
					$time, addr, proc_rdata, expected);
			end
		end
		@(posedge clk);
		proc_req <= '0;
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
		end
	endtask

	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		int st;
		int err0;
		int count0;
		logic [3:0] blk;
		logic [1:0] off;
		void'($urandom(32'h6fa5291b));
		proc_reset = 1'b1;
		proc_req   = '0;
		repeat (8) @(posedge clk);
		proc_reset <= 1'b0;

		err0 = errors;
		repeat (4) begin
			@(negedge clk);
			check_condition(!mem_req.read && !mem_req.write, "memory request without a request");
		end
		access(1'b0, 30'h0000_1231, '0, st);
		check_condition(st > 0, "first read did not miss");
		report_test("reset and first miss", err0);

		err0 = errors;
		access(1'b0, 30'h0000_1233, '0, st);
		check_condition(st == 0, "read of a cached block stalled");
		report_test("read hit", err0);

		err0   = errors;
		count0 = mem_writes;
		access(1'b1, 30'h0000_1232, 32'hcafe_0003, st);
		check_condition(st == 0, "write hit stalled");
		access(1'b0, 30'h0000_1232, '0, st);
		check_condition(mem_writes == count0, "write hit reached memory");
		report_test("write hit", err0);

		// set 1 gets two dirty lines and then a third tag
		err0 = errors;
		access(1'b1, {26'h100, 2'd1, 2'd3}, 32'h1111_0100, st);
		access(1'b1, {26'h200, 2'd1, 2'd3}, 32'h2222_0200, st);
		count0 = mem_writes;
		access(1'b0, {26'h300, 2'd1, 2'd0}, '0, st);
		check_condition(mem_writes == count0 + 1, "dirty victim not written back");
		check_condition(last_write_addr == {26'h100, 2'd1}, "write-back to the wrong block");
		access(1'b0, {26'h100, 2'd1, 2'd3}, '0, st);
		report_test("dirty eviction", err0);

		// in set 2 C must evict B after A B A
		err0 = errors;
		access(1'b0, {26'h400, 2'd2, 2'd1}, '0, st);
		access(1'b0, {26'h500, 2'd2, 2'd1}, '0, st);
		access(1'b0, {26'h400, 2'd2, 2'd2}, '0, st);
		access(1'b0, {26'h600, 2'd2, 2'd1}, '0, st);
		count0 = mem_reads;
		access(1'b0, {26'h400, 2'd2, 2'd0}, '0, st);
		check_condition(mem_reads == count0 && st == 0, "recently used line was evicted");
		report_test("lru replacement", err0);

		err0 = errors;
		repeat (300) begin
			blk = 4'($urandom % 16);
			off = 2'($urandom % 4);
			if ($urandom % 2) begin
				access(1'b1, {24'd0, blk, off}, $urandom, st);
			end else begin
				access(1'b0, {24'd0, blk, off}, '0, st);
			end
		end
		report_test("random mix", err0);

		errors = errors + i_dcache_top.i_dcache_props.fail_count;
		$display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dcache_top.sv
// two-way write-back data cache top, requester must hold proc_req while proc_stall is high
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_top (
	input  logic                   clk,
	input  logic                   proc_reset,
	// requester side
	input  dcache_pkg::proc_req_t  proc_req,
	output logic [`DC_WORD_W-1:0]  proc_rdata,
	output logic                   proc_stall,
	// block memory side
	output dcache_pkg::mem_req_t   mem_req,
	input  logic [`DC_LINE_W-1:0]  mem_rdata,
	input  logic                   mem_ready
);

	// --------------------
	// controller to ways
	// --------------------
	logic word_write;
	logic fill;
	logic clean;

	// ways to controller
	logic                        hit;
	logic                        victim_dirty;
	logic [`DC_BLOCK_ADDR_W-1:0] victim_block_addr;
	logic [`DC_LINE_W-1:0]       victim_line;

	dcache_ctrl i_dcache_ctrl (
		.clk               (clk),
		.proc_reset        (proc_reset),
		.proc_req          (proc_req),
		.hit               (hit),
		.victim_dirty      (victim_dirty),
		.victim_block_addr (victim_block_addr),
		.victim_line       (victim_line),
		.mem_ready         (mem_ready),
		.proc_stall        (proc_stall),
		.word_write        (word_write),
		.fill              (fill),
		.clean             (clean),
		.mem_req           (mem_req)
	);

	dcache_way_store i_dcache_way_store (
		.clk               (clk),
		.proc_reset        (proc_reset),
		.proc_req          (proc_req),
		.word_write        (word_write),
		.fill              (fill),
		.clean             (clean),
		.mem_rdata         (mem_rdata),
		.hit               (hit),
		.victim_dirty      (victim_dirty),
		.victim_block_addr (victim_block_addr),
		.victim_line       (victim_line),
		.rdata             (proc_rdata)   // valid on a hit
	);

endmodule

`default_nettype wire

// File: dcache_way_store.sv
// two ways of line storage, hit, read mux and LRU, only valid, dirty and LRU bits are reset
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_way_store (
	input  logic                        clk,
	input  logic                        proc_reset,
	input  dcache_pkg::proc_req_t       proc_req,
	input  logic                        word_write,   // write hit, merge word
	input  logic                        fill,         // line arrived from memory
	input  logic                        clean,        // victim written back
	input  logic [`DC_LINE_W-1:0]       mem_rdata,
	output logic                        hit,
	output logic                        victim_dirty,
	output logic [`DC_BLOCK_ADDR_W-1:0] victim_block_addr,
	output logic [`DC_LINE_W-1:0]       victim_line,
	output logic [`DC_WORD_W-1:0]       rdata
);

	// --------------------
	// storage
	// --------------------
	dcache_pkg::line_t ways [2][`DC_NUM_SETS];
	logic [`DC_NUM_SETS-1:0] lru;   // per set, the way to replace next

	// --------------------
	// request decode
	// --------------------
	logic [`DC_SET_BITS-1:0]    set_idx;
	logic [`DC_OFFSET_BITS-1:0] word_idx;
	logic [`DC_TAG_W-1:0]       req_tag;
	logic [1:0]                 way_hit;
	logic                       hit_way;     // way holding the requested line
	logic                       victim;      // way named by the LRU bit
	logic                       touch;       // request served from a way
	dcache_pkg::line_t          hit_line;
	dcache_pkg::line_t          victim_entry;

	assign set_idx  = proc_req.addr[`DC_OFFSET_BITS +: `DC_SET_BITS];
	assign word_idx = proc_req.addr[`DC_OFFSET_BITS-1:0];
	assign req_tag  = proc_req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];

	// both ways compared in the request cycle
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = ways[w][set_idx].valid && (ways[w][set_idx].tag == req_tag);
		end
	end

	assign hit     = |way_hit;
	assign hit_way = way_hit[1];   // a tag lives in at most one way
	assign touch   = (proc_req.read | proc_req.write) & hit;

	// --------------------
	// read path
	// --------------------
	assign hit_line = ways[hit_way][set_idx];
	assign rdata    = hit_line.data[word_idx*`DC_WORD_W +: `DC_WORD_W];

	// --------------------
	// victim view
	// --------------------
	assign victim       = lru[set_idx];
	assign victim_entry = ways[victim][set_idx];

	// an invalid victim never needs a write-back
	assign victim_dirty      = victim_entry.valid & victim_entry.dirty;
	assign victim_block_addr = {victim_entry.tag, set_idx};   // victim's own block
	assign victim_line       = victim_entry.data;

	// --------------------
	// array update
	// --------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < `DC_NUM_SETS; s++) begin
				ways[0][s].valid <= 1'b0;
				ways[0][s].dirty <= 1'b0;
				ways[1][s].valid <= 1'b0;
				ways[1][s].dirty <= 1'b0;
			end
			lru <= '0;   // way 0 first everywhere
		end else begin
			// store hit, merge one word into the line
			if (word_write) begin
				ways[hit_way][set_idx].data[word_idx*`DC_WORD_W +: `DC_WORD_W] <= proc_req.wdata;
				ways[hit_way][set_idx].dirty <= 1'b1;
			end

			if (clean) begin
				ways[victim][set_idx].dirty <= 1'b0;   // memory now matches
			end

			// new line lands in the victim way, clean
			if (fill) begin
				ways[victim][set_idx].valid <= 1'b1;
				ways[victim][set_idx].dirty <= 1'b0;
				ways[victim][set_idx].tag   <= req_tag;
				ways[victim][set_idx].data  <= mem_rdata;
			end

			// LRU points away from the way just used
			if (fill) begin
				lru[set_idx] <= ~victim;
			end else if (touch) begin
				lru[set_idx] <= ~hit_way;
			end
		end
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
dcache_pkg.sv
dcache_way_store.sv
dcache_ctrl.sv
dcache_top.sv
dcache_mem_model.sv
dcache_props.sv
dcache_tb.sv
